// ==== sim.f ====
rs_dec_pkg.sv
rs_dec_csr.sv
rs_dec_fifo.sv
rs_dec_requestor.sv
rs_dec_afu.sv
tb_host_mem.sv
tb_rs_dec.sv

// ==== tb_rs_dec.sv ====
// Reed-Solomon requestor testbench
`default_nettype none

module tb_rs_dec
  import rs_dec_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int FIFO_DEPTH  = 512;
  localparam int BYTE_GAP    = 8;
  localparam int TOTAL_LINES = 26; // Lines of all jobs together
  localparam int CYCLE_LIMIT = 2 * TOTAL_LINES * CL_BYTES * BYTE_GAP + 5000;

  logic        clk;
  logic        reset;
  logic        mmio_wr_valid;
  t_csr_reg    mmio_wr_addr;
  logic [63:0] mmio_wr_data;
  logic        rd_req_valid;
  t_cl_addr    rd_req_addr;
  logic        rd_almost_full;
  logic        rd_rsp_valid;
  t_cl_data    rd_rsp_data;
  logic        wr_req_valid;
  t_cl_addr    wr_req_addr;
  t_cl_data    wr_req_data;
  logic        wr_almost_full;
  logic        wr_rsp_valid;
  logic [7:0]  dec_data_out;
  logic        dec_valid_out;
  logic [7:0]  dec_data_in;
  logic        dec_valid_in;
  logic        bp_en;
  logic [7:0]  wr_delay;

  int          cycle_count;
  int          err_count;
  int          tests_run;
  int          tests_failed;
  logic        job_active;
  t_cl_addr    job_dst;
  t_cl_addr    job_dsm;
  t_cl_addr    exp_rd_addr;
  int          job_lines;
  int          rd_reqs;
  int          dec_bytes;
  int          wr_lines;
  int          rsp_cnt;
  int          status_cnt;
  int          last_dec_cyc;
  logic        rd_af_prev;
  logic        wr_af_prev;
  logic [7:0]  exp_bytes [$];
  t_cl_data    src_lines [$];
  logic        dly_v [3];
  logic [7:0]  dly_d [3];

  rs_dec_afu #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .BYTE_GAP   (BYTE_GAP)
  ) rs_dec_afu_inst (
    .clk            (clk),
    .reset          (reset),
    .mmio_wr_valid  (mmio_wr_valid),
    .mmio_wr_addr   (mmio_wr_addr),
    .mmio_wr_data   (mmio_wr_data),
    .rd_req_valid   (rd_req_valid),
    .rd_req_addr    (rd_req_addr),
    .rd_almost_full (rd_almost_full),
    .rd_rsp_valid   (rd_rsp_valid),
    .rd_rsp_data    (rd_rsp_data),
    .wr_req_valid   (wr_req_valid),
    .wr_req_addr    (wr_req_addr),
    .wr_req_data    (wr_req_data),
    .wr_almost_full (wr_almost_full),
    .wr_rsp_valid   (wr_rsp_valid),
    .dec_data_out   (dec_data_out),
    .dec_valid_out  (dec_valid_out),
    .dec_data_in    (dec_data_in),
    .dec_valid_in   (dec_valid_in)
  );

  tb_host_mem host_mem_inst (
    .clk            (clk),
    .reset          (reset),
    .bp_en          (bp_en),
    .wr_delay       (wr_delay),
    .rd_req_valid   (rd_req_valid),
    .rd_req_addr    (rd_req_addr),
    .rd_almost_full (rd_almost_full),
    .rd_rsp_valid   (rd_rsp_valid),
    .rd_rsp_data    (rd_rsp_data),
    .wr_req_valid   (wr_req_valid),
    .wr_req_addr    (wr_req_addr),
    .wr_req_data    (wr_req_data),
    .wr_almost_full (wr_almost_full),
    .wr_rsp_valid   (wr_rsp_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Stand-in decoder returns each byte XOR 5a three cycles later
  always @(negedge clk) begin
    dec_valid_in <= dly_v[2];
    dec_data_in  <= dly_d[2];
    dly_v[2]     <= dly_v[1];
    dly_d[2]     <= dly_d[1];
    dly_v[1]     <= dly_v[0];
    dly_d[1]     <= dly_d[0];
    dly_v[0]     <= dec_valid_out;
    dly_d[0]     <= dec_data_out ^ 8'h5a;
  end

  task automatic flag_mismatch(input string name, input logic [63:0] exp_val,
                               input logic [63:0] got_val);
    err_count++;
    $display("ERR %0t %s expected %0h got %0h", $time, name, exp_val, got_val);
  endtask

  task automatic log_failure(input string what);
    err_count++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // Bus monitor sees the values that the DUT and host saw in the cycle just ended
  always @(posedge clk) begin : monitor
    logic [7:0] exp_byte;
    cycle_count = cycle_count + 1;
    if (rd_req_valid) begin
      if (!job_active) begin
        log_failure("read request while no job was started");
      end else if (rd_req_addr !== exp_rd_addr) begin
        flag_mismatch("rd_req_addr", exp_rd_addr, rd_req_addr);
      end
      if (rd_af_prev) log_failure("read request in the cycle after rd_almost_full");
      exp_rd_addr = exp_rd_addr + 1;
      rd_reqs++;
    end
    if (dec_valid_out) begin
      if (exp_bytes.size() == 0) begin
        log_failure("decoder byte when none was due");
      end else begin
        exp_byte = exp_bytes.pop_front();
        if (dec_data_out !== exp_byte) flag_mismatch("dec_data_out", exp_byte, dec_data_out);
      end
      if ((last_dec_cyc >= 0) && (cycle_count - last_dec_cyc < BYTE_GAP)) begin
        log_failure("two decoder bytes closer than the byte gap");
      end
      last_dec_cyc = cycle_count;
      dec_bytes++;
    end
    if (rd_reqs * CL_BYTES - dec_bytes > FIFO_DEPTH) log_failure("read credit above FIFO depth");
    if (wr_req_valid) begin
      if (!job_active) begin
        log_failure("write request while no job was started");
      end else if (wr_req_addr === job_dsm) begin
        status_cnt++;
        if (wr_req_data !== t_cl_data'(1)) flag_mismatch("wr_req_data", 1, wr_req_data[63:0]);
        if (rsp_cnt < job_lines) log_failure("status write before the last write response");
      end else begin
        if (wr_req_addr !== job_dst + wr_lines) begin
          flag_mismatch("wr_req_addr", job_dst + wr_lines, wr_req_addr);
        end
        wr_lines++;
      end
      if (wr_af_prev) log_failure("write request in the cycle after wr_almost_full");
    end
    if (wr_rsp_valid) rsp_cnt++;
    rd_af_prev = rd_almost_full;
    wr_af_prev = wr_almost_full;
  end

  task automatic mmio_write(input t_csr_reg addr, input logic [63:0] data);
    mmio_wr_valid = 1'b1;
    mmio_wr_addr  = addr;
    mmio_wr_data  = data;
    @(negedge clk);
    mmio_wr_valid = 1'b0;
  endtask

  task automatic print_result(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic idle_after_reset();
    int errs;
    int i;
    errs = err_count;
    reset = 1'b1;
    for (i = 0; i < 45; i++) begin
      @(negedge clk);
      if (i == 4) reset = 1'b0; // Five rising edges seen in reset
      if (rd_req_valid !== 1'b0) flag_mismatch("rd_req_valid", 0, rd_req_valid);
      if (wr_req_valid !== 1'b0) flag_mismatch("wr_req_valid", 0, wr_req_valid);
      if (dec_valid_out !== 1'b0) flag_mismatch("dec_valid_out", 0, dec_valid_out);
    end
    print_result("idle_after_reset", errs);
  endtask

  task automatic run_job(input string name, input t_cl_addr src, input t_cl_addr dst,
                         input t_cl_addr dsm, input int lines, input logic bp,
                         input int delay);
    int       errs;
    int       i;
    int       b;
    t_cl_addr a;
    t_cl_data got_line;
    t_cl_data exp_line;
    errs = err_count;
    @(posedge clk);
    host_mem_inst.fill_lines(src, lines);
    @(negedge clk);
    src_lines.delete();
    exp_bytes.delete();
    for (i = 0; i < lines; i++) begin
      a = src + i;
      src_lines.push_back(host_mem_inst.mem[a[11:0]]);
      for (b = CL_BYTES - 1; b >= 0; b--) begin
        exp_bytes.push_back(src_lines[i][b*8 +: 8]); // Byte 63 leaves first
      end
    end
    job_dst     = dst;
    job_dsm     = dsm;
    job_lines   = lines;
    exp_rd_addr = src;
    rd_reqs     = 0;
    dec_bytes   = 0;
    wr_lines    = 0;
    rsp_cnt     = 0;
    status_cnt  = 0;
    job_active  = 1'b1;
    bp_en       = bp;
    wr_delay    = 8'(delay);
    mmio_write(REG_SRC_ADDR, 64'(src));
    mmio_write(REG_SRC_SIZE, 64'(lines));
    mmio_write(REG_DST_ADDR, 64'(dst));
    mmio_write(REG_DST_SIZE, 64'(lines));
    mmio_write(REG_DSM_ADDR, 64'(dsm));
    mmio_write(REG_CONTROL, CTRL_START);
    while (status_cnt == 0) @(negedge clk);
    bp_en = 1'b0;
    while (rsp_cnt < lines + 1) @(negedge clk);
    repeat (40) @(negedge clk); // Room for a second status write to show up
    job_active = 1'b0;
    if (exp_bytes.size() != 0) log_failure("source bytes never reached the decoder");
    if (rd_reqs != lines) flag_mismatch("read request count", lines, rd_reqs);
    if (wr_lines != lines) flag_mismatch("line write count", lines, wr_lines);
    if (status_cnt != 1) flag_mismatch("status write count", 1, status_cnt);
    for (i = 0; i < lines; i++) begin
      a        = dst + i;
      got_line = host_mem_inst.mem[a[11:0]];
      exp_line = src_lines[i] ^ {CL_BYTES{8'h5a}};
      for (b = CL_BYTES - 1; b >= 0; b--) begin
        if (got_line[b*8 +: 8] !== exp_line[b*8 +: 8]) begin
          flag_mismatch($sformatf("wr_req_data line %0d byte %0d", i, b),
                        exp_line[b*8 +: 8], got_line[b*8 +: 8]);
          break;
        end
      end
    end
    a        = dsm;
    got_line = host_mem_inst.mem[a[11:0]];
    if (got_line !== t_cl_data'(1)) flag_mismatch("status line", 1, got_line[63:0]);
    print_result(name, errs);
  endtask

  task automatic single_line_job();
    run_job("single_line_job", 32'h100, 32'h800, 32'hf00, 1, 1'b0, 2);
  endtask

  task automatic credit_limited_job();
    run_job("credit_limited_job", 32'h200, 32'h900, 32'hf01, 12, 1'b0, 2);
  endtask

  task automatic back_pressure_job();
    run_job("back_pressure_job", 32'h300, 32'ha00, 32'hf02, 8, 1'b1, 3);
  endtask

  task automatic paced_bytes_job();
    run_job("paced_bytes_job", 32'h400, 32'hb00, 32'hf03, 2, 1'b0, 0);
  endtask

  task automatic delayed_response_job();
    run_job("delayed_response_job", 32'h500, 32'hc00, 32'hf04, 3, 1'b0, 40);
  endtask

  initial begin
    while (cycle_count < CYCLE_LIMIT) @(negedge clk);
    $display("Timeout after %0d cycles, the job never completed", CYCLE_LIMIT);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    reset         = 1'b1;
    mmio_wr_valid = 1'b0;
    mmio_wr_addr  = REG_CONTROL;
    mmio_wr_data  = '0;
    dec_valid_in  = 1'b0;
    dec_data_in   = '0;
    bp_en         = 1'b0;
    wr_delay      = 8'd2;
    job_active    = 1'b0;
    job_dst       = '0;
    job_dsm       = '1;
    exp_rd_addr   = '0;
    last_dec_cyc  = -1;
    rd_af_prev    = 1'b0;
    wr_af_prev    = 1'b0;
    dly_v         = '{default: 1'b0};
    dly_d         = '{default: 8'h00};
    idle_after_reset();
    single_line_job();
    credit_limited_job();
    back_pressure_job();
    paced_bytes_job();
    delayed_response_job();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_host_mem.sv ====
// Host memory model
`default_nettype none

module tb_host_mem
  import rs_dec_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       bp_en,
  input  wire logic [7:0] wr_delay,
  input  wire logic       rd_req_valid,
  input  wire t_cl_addr   rd_req_addr,
  output logic            rd_almost_full,
  output logic            rd_rsp_valid,
  output t_cl_data        rd_rsp_data,
  input  wire logic       wr_req_valid,
  input  wire t_cl_addr   wr_req_addr,
  input  wire t_cl_data   wr_req_data,
  output logic            wr_almost_full,
  output logic            wr_rsp_valid
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RD_LATENCY = 6; // Cycles from a read request to its response

  t_cl_data mem [4096];          // Indexed by the low twelve bits of the line address
  t_cl_addr rd_addr_q [$];
  int       rd_due_q [$];
  int       wr_due_q [$];
  int       cyc;
  integer   seed;

  initial begin
    seed           = 32'hdadac59c;
    cyc            = 0;
    rd_almost_full = 1'b0;
    rd_rsp_valid   = 1'b0;
    rd_rsp_data    = '0;
    wr_almost_full = 1'b0;
    wr_rsp_valid   = 1'b0;
  end

  // Source lines get random words mixed with their own address
  task automatic fill_lines(input t_cl_addr base, input int lines);
    t_cl_addr a;
    t_cl_data line;
    int       i;
    int       w;
    for (i = 0; i < lines; i++) begin
      a = base + i;
      for (w = 0; w < 16; w++) begin
        line[w*32 +: 32] = $random(seed) ^ a;
      end
      mem[a[11:0]] = line;
    end
  endtask

  always @(negedge clk) begin : serve
    t_cl_addr a;
    integer   r;
    if (reset) begin
      rd_addr_q.delete();
      rd_due_q.delete();
      wr_due_q.delete();
      rd_rsp_valid   <= 1'b0;
      wr_rsp_valid   <= 1'b0;
      rd_almost_full <= 1'b0;
      wr_almost_full <= 1'b0;
    end else begin
      cyc = cyc + 1;
      if (rd_req_valid) begin
        rd_addr_q.push_back(rd_req_addr);
        rd_due_q.push_back(cyc + RD_LATENCY);
      end
      if (wr_req_valid) begin
        mem[wr_req_addr[11:0]] = wr_req_data; // The status write lands here too
        wr_due_q.push_back(cyc + wr_delay);
      end
      rd_rsp_valid <= 1'b0;
      if ((rd_due_q.size() > 0) && (rd_due_q[0] <= cyc)) begin
        a = rd_addr_q.pop_front();
        void'(rd_due_q.pop_front());
        rd_rsp_valid <= 1'b1;
        rd_rsp_data  <= mem[a[11:0]];
      end
      wr_rsp_valid <= 1'b0;
      if ((wr_due_q.size() > 0) && (wr_due_q[0] <= cyc)) begin
        void'(wr_due_q.pop_front());
        wr_rsp_valid <= 1'b1; // At most one response per cycle
      end
      r = $random(seed);
      rd_almost_full <= bp_en && r[0];
      wr_almost_full <= bp_en && r[1];
    end
  end

endmodule

`default_nettype wire

// ==== rs_dec_afu.sv ====
// Reed-Solomon decoder AFU top level
`default_nettype none

module rs_dec_afu
  import rs_dec_pkg::*;
#(
  parameter int FIFO_DEPTH = 512,
  parameter int BYTE_GAP   = 8
)
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        mmio_wr_valid,
  input  wire t_csr_reg    mmio_wr_addr,
  input  wire logic [63:0] mmio_wr_data,
  output logic             rd_req_valid,
  output t_cl_addr         rd_req_addr,
  input  wire logic        rd_almost_full,
  input  wire logic        rd_rsp_valid,
  input  wire t_cl_data    rd_rsp_data,
  output logic             wr_req_valid,
  output t_cl_addr         wr_req_addr,
  output t_cl_data         wr_req_data,
  input  wire logic        wr_almost_full,
  input  wire logic        wr_rsp_valid,
  output logic [7:0]       dec_data_out,
  output logic             dec_valid_out,
  input  wire logic [7:0]  dec_data_in,
  input  wire logic        dec_valid_in
);

  logic     start;
  t_cl_addr src_addr;
  t_cl_addr src_size;
  t_cl_addr dst_addr;
  t_cl_addr dst_size;
  t_cl_addr dsm_addr;

  rs_dec_csr csr_inst (
    .clk           (clk),
    .reset         (reset),
    .mmio_wr_valid (mmio_wr_valid),
    .mmio_wr_addr  (mmio_wr_addr),
    .mmio_wr_data  (mmio_wr_data),
    .start         (start),
    .src_addr      (src_addr),
    .src_size      (src_size),
    .dst_addr      (dst_addr),
    .dst_size      (dst_size),
    .dsm_addr      (dsm_addr)
  );

  rs_dec_requestor #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .BYTE_GAP   (BYTE_GAP)
  ) requestor_inst (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .src_addr       (src_addr),
    .src_size       (src_size),
    .dst_addr       (dst_addr),
    .dst_size       (dst_size),
    .dsm_addr       (dsm_addr),
    .rd_almost_full (rd_almost_full),
    .rd_rsp_valid   (rd_rsp_valid),
    .rd_rsp_data    (rd_rsp_data),
    .rd_req_valid   (rd_req_valid),
    .rd_req_addr    (rd_req_addr),
    .wr_almost_full (wr_almost_full),
    .wr_rsp_valid   (wr_rsp_valid),
    .wr_req_valid   (wr_req_valid),
    .wr_req_addr    (wr_req_addr),
    .wr_req_data    (wr_req_data),
    .dec_data_in    (dec_data_in),
    .dec_valid_in   (dec_valid_in),
    .dec_data_out   (dec_data_out),
    .dec_valid_out  (dec_valid_out)
  );

endmodule

`default_nettype wire

// ==== rs_dec_requestor.sv ====
// Host memory requestor
`default_nettype none

module rs_dec_requestor
  import rs_dec_pkg::*;
#(
  parameter int FIFO_DEPTH = 512,
  parameter int BYTE_GAP   = 8
)
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       start,
  input  wire t_cl_addr   src_addr,
  input  wire t_cl_addr   src_size,
  input  wire t_cl_addr   dst_addr,
  input  wire t_cl_addr   dst_size,
  input  wire t_cl_addr   dsm_addr,
  input  wire logic       rd_almost_full,
  input  wire logic       rd_rsp_valid,
  input  wire t_cl_data   rd_rsp_data,
  output logic            rd_req_valid,
  output t_cl_addr        rd_req_addr,
  input  wire logic       wr_almost_full,
  input  wire logic       wr_rsp_valid,
  output logic            wr_req_valid,
  output t_cl_addr        wr_req_addr,
  output t_cl_data        wr_req_data,
  input  wire logic [7:0] dec_data_in,
  input  wire logic       dec_valid_in,
  output logic [7:0]      dec_data_out,
  output logic            dec_valid_out
);

  localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;
  localparam int IDX_W = $clog2(CL_BYTES);

  logic             enq_en;
  t_cl_data         enq_data;
  logic             deq_en;
  logic [7:0]       deq_data;
  logic             not_empty;
  logic [CNT_W-1:0] count;

  rs_dec_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo_inst (
    .clk       (clk),
    .reset     (reset),
    .enq_en    (enq_en),
    .enq_data  (enq_data),
    .deq_en    (deq_en),
    .deq_data  (deq_data),
    .not_empty (not_empty),
    .count     (count)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      enq_en <= 1'b0;
    end else begin
      enq_en <= rd_rsp_valid; // Every read response is accepted
    end
  end

  always_ff @(posedge clk) begin
    if (rd_rsp_valid) begin
      enq_data <= rd_rsp_data;
    end
  end

  // Pacer sends one byte at most every BYTE_GAP cycles
  logic [3:0] gap_cnt;

  assign deq_en = not_empty && (gap_cnt == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dec_valid_out <= 1'b0;
      gap_cnt       <= '0;
    end else begin
      dec_valid_out <= deq_en;
      if (deq_en) begin
        gap_cnt <= 4'(BYTE_GAP - 1);
      end else if (gap_cnt != '0) begin
        gap_cnt <= gap_cnt - 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (deq_en) begin
      dec_data_out <= deq_data;
    end
  end

  t_rd_state        rd_state;
  t_cl_addr         rd_offset;
  logic [CNT_W-1:0] outstanding;  // Bytes requested but not yet counted by the FIFO
  logic [CNT_W:0]   credit_sum;
  logic             room;
  logic             rd_issue;

  assign credit_sum = outstanding + count;
  assign room       = (credit_sum + CL_BYTES) <= FIFO_DEPTH;
  assign rd_issue   = (rd_state == RD_FETCH) && (rd_offset != src_size) &&
                      room && !rd_almost_full;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_state     <= RD_IDLE;
      rd_offset    <= '0;
      outstanding  <= '0;
      rd_req_valid <= 1'b0;
    end else begin
      rd_req_valid <= rd_issue;
      // Credit passes from outstanding to count as the line is enqueued
      outstanding  <= outstanding
                    + (rd_issue ? CNT_W'(CL_BYTES) : CNT_W'(0))
                    - (enq_en ? CNT_W'(CL_BYTES) : CNT_W'(0));
      case (rd_state)
        RD_IDLE: begin
          if (start) begin
            rd_offset <= '0;
            rd_state  <= RD_FETCH;
          end
        end
        RD_FETCH: begin
          if (rd_offset == src_size) begin
            rd_state <= RD_DONE;
          end else if (!room) begin
            rd_state <= RD_WAIT;
          end else if (rd_issue) begin
            rd_offset <= rd_offset + 1'b1;
          end
        end
        RD_WAIT: begin
          if (room) begin
            rd_state <= RD_FETCH;
          end
        end
        RD_DONE: begin
          if ((outstanding == '0) && !not_empty) begin
            rd_state <= RD_IDLE; // All source bytes went to the decoder
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_issue) begin
      rd_req_addr <= src_addr + rd_offset;
    end
  end

  t_wr_state        wr_state;
  t_cl_addr         wr_offset;
  t_cl_addr         wr_rsp_cnt;
  t_cl_data         line_reg;
  t_cl_data         full_line;
  logic [IDX_W-1:0] pack_idx;
  logic             line_done;
  logic             wr_line;
  logic             wr_status;

  assign line_done = dec_valid_in && (pack_idx == '0);

  always_comb begin
    full_line      = line_reg;
    full_line[7:0] = dec_data_in; // 64th byte of the group
  end

  assign wr_line   = !wr_almost_full &&
                     (((wr_state == WR_COLLECT) && (wr_offset != dst_size) && line_done) ||
                      (wr_state == WR_DATA));
  assign wr_status = (wr_state == WR_FINISH) && (wr_rsp_cnt == dst_size) && !wr_almost_full;

  // First byte of each group fills byte 63
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pack_idx <= '1;
    end else if (start) begin
      pack_idx <= '1;
    end else if (dec_valid_in) begin
      pack_idx <= pack_idx - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid_in) begin
      line_reg[pack_idx*8 +: 8] <= dec_data_in;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_state     <= WR_IDLE;
      wr_offset    <= '0;
      wr_rsp_cnt   <= '0;
      wr_req_valid <= 1'b0;
    end else begin
      wr_req_valid <= wr_line || wr_status;
      if (start) begin
        wr_rsp_cnt <= '0;
      end else if (wr_rsp_valid) begin
        wr_rsp_cnt <= wr_rsp_cnt + 1'b1;
      end
      if (wr_line) begin
        wr_offset <= wr_offset + 1'b1;
      end
      case (wr_state)
        WR_IDLE: begin
          if (start) begin
            wr_offset <= '0;
            wr_state  <= WR_COLLECT;
          end
        end
        WR_COLLECT: begin
          if (wr_offset == dst_size) begin
            wr_state <= WR_FINISH;
          end else if (line_done && wr_almost_full) begin
            wr_state <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (!wr_almost_full) begin
            wr_state <= WR_COLLECT;
          end
        end
        WR_FINISH: begin
          if (wr_status) begin
            wr_state <= WR_DONE;
          end
        end
        WR_DONE:  wr_state <= WR_IDLE;
        default:  wr_state <= WR_IDLE;
      endcase
    end
  end

  // The outgoing data register also holds a line stalled by almost-full
  always_ff @(posedge clk) begin
    if (wr_status) begin
      wr_req_addr <= dsm_addr;
      wr_req_data <= t_cl_data'(1);
    end else begin
      if (wr_line) begin
        wr_req_addr <= dst_addr + wr_offset;
      end
      if (line_done && (wr_state == WR_COLLECT)) begin
        wr_req_data <= full_line;
      end
    end
  end

  credit_in_range: assert property (
    @(posedge clk) disable iff (reset) credit_sum <= FIFO_DEPTH
  );

  rd_req_after_room: assert property (
    @(posedge clk) disable iff (reset) rd_req_valid |-> !$past(rd_almost_full)
  );

  wr_req_after_room: assert property (
    @(posedge clk) disable iff (reset) wr_req_valid |-> !$past(wr_almost_full)
  );

endmodule

`default_nettype wire

// ==== rs_dec_fifo.sv ====
// Line-in byte-out FIFO
`default_nettype none

module rs_dec_fifo
  import rs_dec_pkg::*;
#(
  parameter int FIFO_DEPTH = 512
)
(
  input  wire logic                            clk,
  input  wire logic                            reset,
  input  wire logic                            enq_en,
  input  wire t_cl_data                        enq_data,
  input  wire logic                            deq_en,
  output logic [7:0]                           deq_data,
  output logic                                 not_empty,
  output logic [$clog2(FIFO_DEPTH):0]          count
);

  localparam int SLOTS = FIFO_DEPTH / CL_BYTES;
  localparam int PTR_W = $clog2(SLOTS);
  localparam int IDX_W = $clog2(CL_BYTES);
  localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

  t_cl_data         mem [SLOTS];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [IDX_W-1:0] byte_idx;   // Byte of the head line that leaves next
  logic             head_done;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(SLOTS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_done = deq_en && (byte_idx == '0);
  assign deq_data  = mem[rd_ptr][byte_idx*8 +: 8];
  assign not_empty = (count != '0);

  always_ff @(posedge clk) begin
    if (enq_en) begin
      mem[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      byte_idx <= '1;
    end else begin
      if (enq_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (deq_en) begin
        byte_idx <= byte_idx - 1'b1; // Wraps back to byte 63 after byte 0
      end
      if (head_done) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
    end
  end

  // A line in and a byte out may land in the same cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else begin
      count <= count
             + (enq_en ? CNT_W'(CL_BYTES) : CNT_W'(0))
             - (deq_en ? CNT_W'(1) : CNT_W'(0));
    end
  end

  // The requestor's credit check must leave room for a whole line
  enq_has_room: assert property (
    @(posedge clk) disable iff (reset) enq_en |-> (count <= FIFO_DEPTH - CL_BYTES)
  );

  deq_not_empty: assert property (
    @(posedge clk) disable iff (reset) deq_en |-> not_empty
  );

endmodule

`default_nettype wire

// ==== rs_dec_csr.sv ====
// Job descriptor registers
`default_nettype none

module rs_dec_csr
  import rs_dec_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        mmio_wr_valid,
  input  wire t_csr_reg    mmio_wr_addr,
  input  wire logic [63:0] mmio_wr_data,
  output logic             start,
  output t_cl_addr         src_addr,
  output t_cl_addr         src_size,
  output t_cl_addr         dst_addr,
  output t_cl_addr         dst_size,
  output t_cl_addr         dsm_addr
);

  logic start_hit;

  assign start_hit = mmio_wr_valid && (mmio_wr_addr == REG_CONTROL) &&
                     (mmio_wr_data == CTRL_START);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      start <= 1'b0;
    end else begin
      start <= start_hit; // One cycle after the MMIO write
    end
  end

  // Sizes are in cache lines, addresses in line units
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      src_addr <= '0;
      src_size <= '0;
      dst_addr <= '0;
      dst_size <= '0;
      dsm_addr <= '0;
    end else if (mmio_wr_valid) begin
      case (mmio_wr_addr)
        REG_SRC_ADDR: src_addr <= mmio_wr_data[31:0];
        REG_SRC_SIZE: src_size <= mmio_wr_data[31:0];
        REG_DST_ADDR: dst_addr <= mmio_wr_data[31:0];
        REG_DST_SIZE: dst_size <= mmio_wr_data[31:0];
        REG_DSM_ADDR: dsm_addr <= mmio_wr_data[31:0];
        default: begin
          // Control and unused addresses leave the descriptor alone
        end
      endcase
    end
  end

  // Back-to-back start writes from the host would launch the FSMs twice
  start_is_pulse: assert property (
    @(posedge clk) disable iff (reset) start |=> !start
  );

endmodule

`default_nettype wire

// ==== rs_dec_pkg.sv ====
// Reed-Solomon decoder shared definitions
`default_nettype none

package rs_dec_pkg;

  // One host cache line and its address
  typedef logic [31:0]  t_cl_addr;
  typedef logic [511:0] t_cl_data;

  localparam int CL_BYTES = 64;

  // MMIO register map of the job descriptor
  typedef enum logic [2:0] {
    REG_CONTROL  = 3'd0,
    REG_SRC_ADDR = 3'd1,
    REG_SRC_SIZE = 3'd2,
    REG_DST_ADDR = 3'd3,
    REG_DST_SIZE = 3'd4,
    REG_DSM_ADDR = 3'd5
  } t_csr_reg;

  localparam logic [63:0] CTRL_START = 64'd1; // Written to REG_CONTROL to launch a job

  // Read side issues source line requests under a byte credit
  typedef enum logic [1:0] {
    RD_IDLE  = 2'd0,
    RD_FETCH = 2'd1,
    RD_WAIT  = 2'd2, // FIFO cannot take another line yet
    RD_DONE  = 2'd3
  } t_rd_state;

  // Write side packs decoded bytes and finishes with the status write
  typedef enum logic [2:0] {
    WR_IDLE    = 3'd0,
    WR_COLLECT = 3'd1,
    WR_DATA    = 3'd2, // A full line waits for the write channel
    WR_FINISH  = 3'd3,
    WR_DONE    = 3'd4
  } t_wr_state;

endpackage

`default_nettype wire
